// ==== common/lcd_settings.svh ====
`ifndef LCD_SETTINGS_SVH
`define LCD_SETTINGS_SVH

// clock cycles per timing unit, 1 for simulation
`define LCD_TIME_UNIT 1

// init and power-up waits in units
`define LCD_POWERUP_WAIT 500
`define LCD_CMD_PULSE 10
`define LCD_SHORT_WAIT 50
`define LCD_CLEAR_WAIT 200
`define LCD_ENTRY_WAIT 100

// request write cycle in units
`define LCD_WR_SETUP 1
`define LCD_WR_HIGH 13
`define LCD_WR_CYCLE 50

// panel geometry
`define LCD_COLS 16
`define LCD_LINES 2

`endif

// ==== common/lcd_pkg.sv ====
package lcd_pkg;

	// panel configuration bits, msb first
	typedef struct packed {
		logic two_lines;   // function set N
		logic font_5x10;   // function set F
		logic display_on;  // display control D
		logic cursor_on;   // display control C
		logic blink_on;    // display control B
		logic increment;   // entry mode I/D
		logic shift;       // entry mode S
	} lcd_cfg_t;

	// base opcodes, option bits are or'ed in by the driver
	localparam logic [7:0] OP_FUNCTION_SET = 8'h30;  // 8-bit bus
	localparam logic [7:0] OP_DISPLAY_CTRL = 8'h08;
	localparam logic [7:0] OP_CLEAR        = 8'h01;
	localparam logic [7:0] OP_ENTRY_MODE   = 8'h04;
	localparam logic [7:0] OP_SET_DDRAM    = 8'h80;

	// ddram offset of the first column on line two
	localparam logic [7:0] LINE2_OFFSET = 8'h40;

	// buffer index into the 32 character cells
	// bit 4 picks the line, bits 3..0 the column
	typedef logic [4:0] char_addr_t;

endpackage

// ==== common/lcd_req_if.sv ====
`timescale 1ns/1ps

// request channel between the text writer and the lcd driver
// a request is taken on an edge with valid high and busy low
interface lcd_req_if;
	logic       valid;  // one-cycle strobe
	logic       rs;     // 0 command, 1 character
	logic [7:0] data;
	logic       busy;   // driver not ready for a request

	modport writer (
		output valid,
		output rs,
		output data,
		input  busy
	);

	modport driver (
		input  valid,
		input  rs,
		input  data,
		output busy
	);

endinterface

// ==== lcd_driver/lcd_driver.sv ====
`timescale 1ns/1ps
`include "lcd_settings.svh"

module lcd_driver (
	input  logic             clk,
	input  logic             rst_n,
	input  lcd_pkg::lcd_cfg_t cfg,
	lcd_req_if.driver        req,
	output logic             lcd_e,
	output logic             lcd_rs,
	output logic             lcd_rw,
	output logic [7:0]       lcd_data
);

	localparam int UNIT = `LCD_TIME_UNIT;

	localparam int PWRUP_CYC = `LCD_POWERUP_WAIT * UNIT;

	// init schedule, end of each phase in cycles
	localparam int FS_END       = `LCD_CMD_PULSE * UNIT;
	localparam int FS_WAIT_END  = FS_END + `LCD_SHORT_WAIT * UNIT;
	localparam int DC_END       = FS_WAIT_END + `LCD_CMD_PULSE * UNIT;
	localparam int DC_WAIT_END  = DC_END + `LCD_SHORT_WAIT * UNIT;
	localparam int CLR_END      = DC_WAIT_END + `LCD_CMD_PULSE * UNIT;
	localparam int CLR_WAIT_END = CLR_END + `LCD_CLEAR_WAIT * UNIT;
	localparam int EM_END       = CLR_WAIT_END + `LCD_CMD_PULSE * UNIT;
	localparam int INIT_CYC     = EM_END + `LCD_ENTRY_WAIT * UNIT;

	// request write cycle
	localparam int E_RISE = `LCD_WR_SETUP * UNIT;
	localparam int E_FALL = (`LCD_WR_SETUP + `LCD_WR_HIGH) * UNIT;
	localparam int WR_CYC = (`LCD_WR_SETUP + `LCD_WR_CYCLE) * UNIT;

	localparam int CNT_MAX = (PWRUP_CYC > INIT_CYC) ?
		((PWRUP_CYC > WR_CYC) ? PWRUP_CYC : WR_CYC) :
		((INIT_CYC > WR_CYC) ? INIT_CYC : WR_CYC);
	localparam int CNT_W = $clog2(CNT_MAX + 1);

	typedef enum logic [1:0] {
		ST_PWRUP,
		ST_INIT,
		ST_IDLE,
		ST_WRITE
	} state_t;

	state_t           state;
	state_t           state_n;
	logic [CNT_W-1:0] cnt;
	logic [CNT_W-1:0] cnt_n;
	logic             e_n;
	logic             rs_n;
	logic [7:0]       data_n;
	logic [7:0]       fs_cmd;
	logic [7:0]       dc_cmd;
	logic [7:0]       em_cmd;

	// init commands with the option bits from cfg
	assign fs_cmd = lcd_pkg::OP_FUNCTION_SET | {4'b0000, cfg.two_lines, cfg.font_5x10, 2'b00};
	assign dc_cmd = lcd_pkg::OP_DISPLAY_CTRL |
		{5'b00000, cfg.display_on, cfg.cursor_on, cfg.blink_on};
	assign em_cmd = lcd_pkg::OP_ENTRY_MODE | {6'b000000, cfg.increment, cfg.shift};

	assign lcd_rw = 1'b0;  // write-only panel

	always_comb begin
		state_n = state;
		cnt_n   = cnt + 1'b1;
		case (state)
			ST_PWRUP: begin
				if (cnt == CNT_W'(PWRUP_CYC - 1)) begin
					state_n = ST_INIT;
					cnt_n   = '0;
				end
			end
			ST_INIT: begin
				if (cnt == CNT_W'(INIT_CYC - 1)) begin
					state_n = ST_IDLE;
					cnt_n   = '0;
				end
			end
			ST_IDLE: begin
				cnt_n = '0;
				if (req.valid && !req.busy) begin  // request accepted
					state_n = ST_WRITE;
				end
			end
			default: begin
				if (cnt == CNT_W'(WR_CYC - 1)) begin
					state_n = ST_IDLE;
					cnt_n   = '0;
				end
			end
		endcase
	end

	// pin values for the cycle after this edge
	always_comb begin
		e_n    = 1'b0;
		rs_n   = 1'b0;
		data_n = 8'h00;
		case (state_n)
			ST_INIT: begin
				if (cnt_n < FS_END) begin
					e_n    = 1'b1;
					data_n = fs_cmd;
				end else if (cnt_n >= FS_WAIT_END && cnt_n < DC_END) begin
					e_n    = 1'b1;
					data_n = dc_cmd;
				end else if (cnt_n >= DC_WAIT_END && cnt_n < CLR_END) begin
					e_n    = 1'b1;
					data_n = lcd_pkg::OP_CLEAR;
				end else if (cnt_n >= CLR_WAIT_END && cnt_n < EM_END) begin
					e_n    = 1'b1;
					data_n = em_cmd;
				end
			end
			ST_WRITE: begin
				// capture on acceptance, then hold until back in idle
				rs_n   = (state == ST_IDLE) ? req.rs : lcd_rs;
				data_n = (state == ST_IDLE) ? req.data : lcd_data;
				e_n    = (cnt_n >= E_RISE) && (cnt_n < E_FALL);
			end
			default: begin
				e_n = 1'b0;
			end
		endcase
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			state    <= ST_PWRUP;
			cnt      <= '0;
			lcd_e    <= 1'b0;
			lcd_rs   <= 1'b0;
			lcd_data <= 8'h00;
			req.busy <= 1'b1;
		end else begin
			state    <= state_n;
			cnt      <= cnt_n;
			lcd_e    <= e_n;
			lcd_rs   <= rs_n;
			lcd_data <= data_n;
			req.busy <= (state_n != ST_IDLE);
		end
	end

	a_idle_hold: assert property (@(posedge clk) disable iff (!rst_n)
		(state == ST_IDLE && !req.valid) |=> (state == ST_IDLE));

	a_no_e_in_idle: assert property (@(posedge clk) disable iff (!rst_n)
		(state == ST_IDLE) |-> !lcd_e);

	// the writer must wait for busy to fall
	a_valid_not_busy: assert property (@(posedge clk) disable iff (!rst_n)
		req.valid |-> !req.busy);

endmodule

// ==== design/lcd_text_writer.sv ====
`timescale 1ns/1ps
`include "lcd_settings.svh"

module lcd_text_writer (
	input  logic                clk,
	input  logic                rst_n,
	input  logic                char_we,
	input  lcd_pkg::char_addr_t char_addr,
	input  logic [7:0]          char_data,
	input  logic                refresh,
	output logic                ready,
	lcd_req_if.writer           req
);

	localparam int DEPTH    = `LCD_COLS * `LCD_LINES;
	localparam int LAST_COL = `LCD_COLS - 1;

	logic [7:0]          char_mem [DEPTH];
	logic                pending;     // refresh seen, walk not yet started
	logic                walking;
	logic                init_done;   // driver finished its init
	logic                addr_phase;  // next request is the set-address command
	logic                start;
	logic                issue;
	lcd_pkg::char_addr_t pos;         // cell of the current walk step
	logic [7:0]          line_addr;

	always_ff @(posedge clk) begin
		if (char_we) begin
			char_mem[char_addr] <= char_data;
		end
	end

	assign line_addr = lcd_pkg::OP_SET_DDRAM | (pos[4] ? lcd_pkg::LINE2_OFFSET : 8'h00);

	assign start = pending && !walking && init_done && !req.busy;
	assign issue = walking && !req.valid && !req.busy;
	assign ready = init_done && !pending && !walking;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			pending    <= 1'b0;
			walking    <= 1'b0;
			init_done  <= 1'b0;
			addr_phase <= 1'b0;
			pos        <= '0;
			req.valid  <= 1'b0;
		end else begin
			if (!req.busy) begin
				init_done <= 1'b1;
			end

			// a refresh on the start edge leaves one more walk queued
			if (refresh) begin
				pending <= 1'b1;
			end else if (start) begin
				pending <= 1'b0;
			end

			if (start) begin
				walking    <= 1'b1;
				addr_phase <= 1'b1;
				pos        <= '0;
			end

			if (req.valid) begin
				// busy is low here so the driver has taken it
				req.valid <= 1'b0;
				if (addr_phase) begin
					addr_phase <= 1'b0;
				end else if (pos == 5'(DEPTH - 1)) begin
					walking <= 1'b0;  // last cell of line two
					pos     <= '0;
				end else begin
					pos <= pos + 1'b1;
					if (pos[3:0] == 4'(LAST_COL)) begin
						addr_phase <= 1'b1;  // line wrap
					end
				end
			end else if (issue) begin
				req.valid <= 1'b1;
			end
		end
	end

	// payload sampled from the buffer when issued
	always_ff @(posedge clk) begin
		if (issue) begin
			req.rs   <= !addr_phase;
			req.data <= addr_phase ? line_addr : char_mem[pos];
		end
	end

	a_valid_pulse: assert property (@(posedge clk) disable iff (!rst_n)
		req.valid |=> !req.valid);

endmodule

// ==== design/lcd_display_top.sv ====
`timescale 1ns/1ps

module lcd_display_top (
	input  logic       clk,
	input  logic       rst_n,
	input  logic [6:0] cfg,
	input  logic       char_we,
	input  logic [4:0] char_addr,
	input  logic [7:0] char_data,
	input  logic       refresh,
	output logic       lcd_e,
	output logic       lcd_rs,
	output logic       lcd_rw,
	output logic [7:0] lcd_data,
	output logic       ready
);

	lcd_req_if req_bus ();

	// buffer and refresh walk
	lcd_text_writer u_writer (
		.clk       (clk),
		.rst_n     (rst_n),
		.char_we   (char_we),
		.char_addr (lcd_pkg::char_addr_t'(char_addr)),
		.char_data (char_data),
		.refresh   (refresh),
		.ready     (ready),
		.req       (req_bus.writer)
	);

	// pin timing and panel init
	lcd_driver u_driver (
		.clk      (clk),
		.rst_n    (rst_n),
		.cfg      (lcd_pkg::lcd_cfg_t'(cfg)),
		.req      (req_bus.driver),
		.lcd_e    (lcd_e),
		.lcd_rs   (lcd_rs),
		.lcd_rw   (lcd_rw),
		.lcd_data (lcd_data)
	);

endmodule

// ==== tests/lcd_bus_monitor.sv ====
`timescale 1ns/1ps
`include "lcd_settings.svh"

// passive panel model, samples the pins on rising clk edges
module lcd_bus_monitor (
	input  logic       clk,
	input  logic       rst_n,
	input  logic       lcd_e,
	input  logic       lcd_rs,
	input  logic       lcd_rw,
	input  logic [7:0] lcd_data,
	output logic       cap_valid,  // one cycle per completed e pulse
	output logic [8:0] cap_word,   // {rs, data}
	output int         err_count
);

	localparam int INIT_HIGH = `LCD_CMD_PULSE * `LCD_TIME_UNIT;
	localparam int WR_HIGH   = `LCD_WR_HIGH * `LCD_TIME_UNIT;
	localparam int WR_GAP    = `LCD_WR_CYCLE * `LCD_TIME_UNIT;

	logic       e_q;
	logic [8:0] held;        // bus value seen during the last high sample
	int         high_len;
	int         since_rise;
	int         pulse_no;    // completed pulses since reset
	int         errors = 0;
	int         exp_len;

	assign err_count = errors;

	always @(posedge clk) begin
		cap_valid <= 1'b0;
		if (!rst_n) begin
			e_q        <= 1'b0;
			high_len   <= 0;
			since_rise <= 0;
			pulse_no   <= 0;
		end else begin
			e_q        <= lcd_e;
			since_rise <= since_rise + 1;
			if (lcd_rw !== 1'b0) begin
				$display("monitor: lcd_rw is not low at %0t", $time);
				errors <= errors + 1;
			end
			if (lcd_e) begin
				held <= {lcd_rs, lcd_data};
			end
			if (lcd_e && !e_q) begin  // rising edge of e
				// the first four pulses are the init commands
				if (pulse_no >= 5 && since_rise < WR_GAP) begin
					$display("monitor: request pulses only %0d cycles apart at %0t",
						since_rise, $time);
					errors <= errors + 1;
				end
				since_rise <= 1;
				high_len   <= 1;
			end else if (lcd_e) begin
				high_len <= high_len + 1;
			end
			if (!lcd_e && e_q) begin  // falling edge of e
				exp_len = (pulse_no < 4) ? INIT_HIGH : WR_HIGH;
				if (high_len != exp_len) begin
					$display("monitor: e was high for %0d cycles instead of %0d at %0t",
						high_len, exp_len, $time);
					errors <= errors + 1;
				end
				cap_valid <= 1'b1;
				cap_word  <= held;
				pulse_no  <= pulse_no + 1;
			end
		end
	end

endmodule

// ==== tests/tb_lcd_display.sv ====
`timescale 1ns/1ps
`include "lcd_settings.svh"

module tb_lcd_display;

	localparam int NUM_ROWS    = 4;
	localparam int NUM_CELLS   = `LCD_COLS * `LCD_LINES;
	localparam int UNIT        = `LCD_TIME_UNIT;
	localparam int INIT_LEN    = (`LCD_POWERUP_WAIT + 4 * `LCD_CMD_PULSE +
		2 * `LCD_SHORT_WAIT + `LCD_CLEAR_WAIT + `LCD_ENTRY_WAIT) * UNIT;
	localparam int WR_LEN      = (`LCD_WR_SETUP + `LCD_WR_CYCLE) * UNIT;
	localparam int WALK_LEN    = `LCD_LINES * (`LCD_COLS + 1);  // address plus characters
	localparam int CYCLE_LIMIT = (NUM_ROWS + 1) * (INIT_LEN + WALK_LEN * WR_LEN) * 2;

	logic       clk = 1'b0;
	logic       rst_n;
	logic [6:0] cfg;
	logic       char_we;
	logic [4:0] char_addr;
	logic [7:0] char_data;
	logic       refresh;
	logic       lcd_e;
	logic       lcd_rs;
	logic       lcd_rw;
	logic [7:0] lcd_data;
	logic       ready;
	logic       cap_valid;
	logic [8:0] cap_word;
	int         mon_errors;

	int         compare_errors = 0;
	int         cycle_count = 0;
	integer     seed;
	logic [8:0] cap_q [$];  // captured {rs, data}
	logic [8:0] exp_q [$];
	logic [7:0] model_mem [NUM_CELLS];

	// stimulus table
	string      row_name  [NUM_ROWS];
	logic [6:0] row_cfg   [NUM_ROWS];
	int         row_fill  [NUM_ROWS];  // 0 keep, 1 address pattern, 2 random
	int         row_first [NUM_ROWS];
	int         row_count [NUM_ROWS];
	int         row_extra [NUM_ROWS];  // refresh pulses during the walk
	logic [4:0] patch_addr [5];
	logic [7:0] patch_data [5];

	always #10 clk = ~clk;

	lcd_display_top u_lcd_display_top (
		.clk       (clk),
		.rst_n     (rst_n),
		.cfg       (cfg),
		.char_we   (char_we),
		.char_addr (char_addr),
		.char_data (char_data),
		.refresh   (refresh),
		.lcd_e     (lcd_e),
		.lcd_rs    (lcd_rs),
		.lcd_rw    (lcd_rw),
		.lcd_data  (lcd_data),
		.ready     (ready)
	);

	lcd_bus_monitor u_monitor (
		.clk       (clk),
		.rst_n     (rst_n),
		.lcd_e     (lcd_e),
		.lcd_rs    (lcd_rs),
		.lcd_rw    (lcd_rw),
		.lcd_data  (lcd_data),
		.cap_valid (cap_valid),
		.cap_word  (cap_word),
		.err_count (mon_errors)
	);

	always @(negedge clk) begin
		if (cap_valid) begin
			cap_q.push_back(cap_word);
		end
	end

	always @(posedge clk) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= CYCLE_LIMIT) begin
			$display("timeout: run still going after %0d cycles", CYCLE_LIMIT);
			$display("Test failures found");
			$finish;
		end
	end

	task automatic check_value(input string what, input logic [31:0] expected,
		input logic [31:0] actual);
		if (expected !== actual) begin
			$display("FAILED %s expected %0h actual %0h", what, expected, actual);
			compare_errors++;
		end
	endtask

	task automatic set_row(input int r, input string name, input logic [6:0] c,
		input int fill, input int first, input int count, input int extra);
		row_name[r]  = name;
		row_cfg[r]   = c;
		row_fill[r]  = fill;
		row_first[r] = first;
		row_count[r] = count;
		row_extra[r] = extra;
	endtask

	task automatic set_patch(input int i, input logic [4:0] addr, input logic [7:0] value);
		patch_addr[i] = addr;
		patch_data[i] = value;
	endtask

	// cfg bits N F D C B I/D S from msb down
	task automatic push_init(input logic [6:0] c);
		exp_q.push_back({1'b0, 8'h30 | {4'b0000, c[6], c[5], 2'b00}});
		exp_q.push_back({1'b0, 8'h08 | {5'b00000, c[4], c[3], c[2]}});
		exp_q.push_back({1'b0, 8'h01});
		exp_q.push_back({1'b0, 8'h04 | {6'b000000, c[1], c[0]}});
	endtask

	task automatic push_walk();
		for (int line = 0; line < `LCD_LINES; line++) begin
			exp_q.push_back({1'b0, (line == 0) ? 8'h80 : 8'hc0});
			for (int col = 0; col < `LCD_COLS; col++) begin
				exp_q.push_back({1'b1, model_mem[line * `LCD_COLS + col]});
			end
		end
	endtask

	task automatic write_cell(input logic [4:0] addr, input logic [7:0] value);
		@(posedge clk);
		char_we   <= 1'b1;
		char_addr <= addr;
		char_data <= value;
		model_mem[addr] = value;
	endtask

	task automatic fill_buffer(input int r);
		logic [7:0] value;
		for (int i = 0; i < NUM_CELLS; i++) begin
			if (row_fill[r] != 0) begin
				value = (row_fill[r] == 1) ? 8'(8'h21 + i * 3) : 8'($random(seed));
				write_cell(5'(i), value);
			end
		end
		for (int i = row_first[r]; i < row_first[r] + row_count[r]; i++) begin
			write_cell(patch_addr[i], patch_data[i]);
		end
		@(posedge clk);
		char_we <= 1'b0;
	endtask

	task automatic wait_ready();
		@(posedge clk);
		while (!ready) begin
			@(posedge clk);
		end
	endtask

	task automatic compare_queues(input string name);
		logic [8:0] got;
		int         n;
		check_value({name, " count"}, exp_q.size(), cap_q.size());
		n = 0;
		while (exp_q.size() > 0 && cap_q.size() > 0) begin
			got = cap_q.pop_front();
			check_value($sformatf("%s item %0d", name, n), exp_q.pop_front(), got);
			n++;
		end
		exp_q.delete();
		cap_q.delete();
	endtask

	task automatic run_row(input int r);
		int pulses_left;
		int next_at;
		@(posedge clk);
		rst_n <= 1'b0;
		cfg   <= row_cfg[r];
		repeat (8) @(posedge clk);
		rst_n <= 1'b1;
		cap_q.delete();
		push_init(row_cfg[r]);
		wait_ready();  // all four init commands must be seen by now
		compare_queues({row_name[r], " init"});
		fill_buffer(r);
		push_walk();
		if (row_extra[r] > 0) begin
			push_walk();
		end
		@(posedge clk);
		refresh <= 1'b1;
		@(posedge clk);
		refresh <= 1'b0;
		pulses_left = row_extra[r];
		next_at = 8;
		do begin
			@(posedge clk);
			if (pulses_left > 0 && cap_q.size() >= next_at) begin  // retrigger mid walk
				refresh <= 1'b1;
				@(posedge clk);
				refresh <= 1'b0;
				pulses_left--;
				next_at += 12;
			end
		end while (!ready);
		for (int i = 0; i < 4 * WR_LEN && cap_q.size() < exp_q.size(); i++) begin
			@(posedge clk);
		end
		repeat (2 * WR_LEN) @(posedge clk);  // room for any stray extra write
		compare_queues({row_name[r], " walk"});
	endtask

	initial begin
		rst_n     = 1'b0;
		cfg       = 7'h00;
		char_we   = 1'b0;
		char_addr = 5'd0;
		char_data = 8'h00;
		refresh   = 1'b0;
		seed      = 32'hd0a6c117;
		set_row(0, "pattern_walk", 7'h52, 1, 0, 0, 0);
		set_row(1, "overwrite", 7'h7f, 0, 0, 4, 0);
		set_row(2, "random_retrigger", 7'h23, 2, 0, 0, 1);
		set_row(3, "double_retrigger", 7'h1c, 0, 4, 1, 2);
		set_patch(0, 5'd0, 8'h48);
		set_patch(1, 5'd15, 8'h21);
		set_patch(2, 5'd16, 8'h7e);
		set_patch(3, 5'd31, 8'h5a);
		set_patch(4, 5'd7, 8'h2a);
		for (int r = 0; r < NUM_ROWS; r++) begin
			run_row(r);
		end
		repeat (2) @(posedge clk);
		$display("summary: %0d compare errors, %0d monitor errors", compare_errors, mon_errors);
		if (compare_errors == 0 && mon_errors == 0) begin
			$display("All tests passed!");
		end else begin
			$display("Test failures found");
		end
		$finish;
	end

endmodule

// ==== all.f ====
+incdir+common
common/lcd_pkg.sv
common/lcd_req_if.sv
lcd_driver/lcd_driver.sv
design/lcd_text_writer.sv
design/lcd_display_top.sv
tests/lcd_bus_monitor.sv
tests/tb_lcd_display.sv

// ==== Bender.yml ====
package:
  name: lcd_display

export_include_dirs:
  - common

sources:
  - include_dirs:
      - common
    files:
      - common/lcd_pkg.sv
      - common/lcd_req_if.sv
      - lcd_driver/lcd_driver.sv
      - design/lcd_text_writer.sv
      - design/lcd_display_top.sv
  - target: simulation
    include_dirs:
      - common
    files:
      - tests/lcd_bus_monitor.sv
      - tests/tb_lcd_display.sv
